/* hw/rv_pkg.sv */
package rv_pkg;

	// ----------------------------------------
	// widths
	// ----------------------------------------
	localparam int XLEN   = 32;
	localparam int REG_AW = 5;

	// major opcodes, bits [6:0]
	localparam logic [6:0] op_r      = 7'b0110011;
	localparam logic [6:0] op_i      = 7'b0010011;
	localparam logic [6:0] op_load   = 7'b0000011;
	localparam logic [6:0] op_store  = 7'b0100011;
	localparam logic [6:0] op_branch = 7'b1100011;
	localparam logic [6:0] op_jal    = 7'b1101111;

	// branch compare selects
	localparam logic [2:0] f3_beq  = 3'b000;
	localparam logic [2:0] f3_bne  = 3'b001;
	localparam logic [2:0] f3_blt  = 3'b100;
	localparam logic [2:0] f3_bge  = 3'b101;
	localparam logic [2:0] f3_bltu = 3'b110;
	localparam logic [2:0] f3_bgeu = 3'b111;

	typedef enum logic [3:0] {
		alu_add, alu_sub, alu_and, alu_or, alu_xor,
		alu_slt, alu_sltu, alu_sll, alu_srl, alu_sra
	} alu_op_e;

	typedef enum logic [2:0] {
		cls_alu, cls_load, cls_store, cls_branch, cls_jal, cls_halt
	} instr_class_e;

	// ----------------------------------------
	// instruction formats, msb first
	// ----------------------------------------
	typedef struct packed {
		logic [6:0] funct7;
		logic [REG_AW-1:0] rs2;
		logic [REG_AW-1:0] rs1;
		logic [2:0] funct3;
		logic [REG_AW-1:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [REG_AW-1:0] rs1;
		logic [2:0] funct3;
		logic [REG_AW-1:0] rd;
		logic [6:0] opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_hi;
		logic [REG_AW-1:0] rs2;
		logic [REG_AW-1:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} s_fmt_t;

	// branch offset bits scattered as in the spec
	typedef struct packed {
		logic imm12;
		logic [5:0] imm10_5;
		logic [REG_AW-1:0] rs2;
		logic [REG_AW-1:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4_1;
		logic imm11;
		logic [6:0] opcode;
	} b_fmt_t;

	typedef struct packed {
		logic imm20;
		logic [9:0] imm10_1;
		logic imm11;
		logic [7:0] imm19_12;
		logic [REG_AW-1:0] rd;
		logic [6:0] opcode;
	} j_fmt_t;

	// one fetched word, five views
	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
		s_fmt_t s_fmt;
		b_fmt_t b_fmt;
		j_fmt_t j_fmt;
	} instr_u;

	typedef struct packed {
		instr_class_e cls;
		alu_op_e op;
		logic [REG_AW-1:0] rs1;
		logic [REG_AW-1:0] rs2;
		logic [REG_AW-1:0] rd;
		logic [2:0] funct3;
		logic [XLEN-1:0] imm;
		logic use_imm;
	} decoded_t;

	// data bus request, strobes are single cycle
	typedef struct packed {
		logic re;
		logic we;
		logic [XLEN-1:0] addr;
		logic [XLEN-1:0] wdata;
	} dmem_req_t;

	typedef struct packed {
		logic we;
		logic [XLEN-1:0] addr;
		logic [XLEN-1:0] data;
	} imem_load_t;

endpackage

/* hw/instr_mem.sv */
module instr_mem import rv_pkg::*; #(
	parameter int ADDR_W = 8
) (
	input  logic clk,
	input  logic [ADDR_W-1:0] rd_addr,
	input  logic rd_en,
	input  imem_load_t load,
	output instr_u rd_data
);

	// word array, one entry per pc value
	logic [XLEN-1:0] mem [0:(2**ADDR_W)-1];

	// program load port, low address bits only
	always_ff @(posedge clk)
	begin
		if (load.we)
			mem[load.addr[ADDR_W-1:0]] <= load.data;
	end

	// registered read, holds until next rd_en
	always_ff @(posedge clk)
	begin
		if (rd_en)
			rd_data <= mem[rd_addr];
	end

endmodule

/* hw/reg_file.sv */
module reg_file import rv_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  logic [REG_AW-1:0] rs1,
	input  logic [REG_AW-1:0] rs2,
	input  logic [REG_AW-1:0] rd,
	input  logic we,
	input  logic [XLEN-1:0] wdata,
	output logic [XLEN-1:0] rs1_val,
	output logic [XLEN-1:0] rs2_val
);

	// x0 has no storage
	logic [XLEN-1:0] regs [1:31];

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
		begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end
		else if (we && (rd != '0))
		begin
			regs[rd] <= wdata;
		end
	end

	// combinational reads, x0 reads as zero
	assign rs1_val = (rs1 == '0) ? '0 : regs[rs1];
	assign rs2_val = (rs2 == '0) ? '0 : regs[rs2];

endmodule

/* hw/instr_decode.sv */
module instr_decode import rv_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  logic latch,
	input  instr_u word,
	output decoded_t dec
);

	instr_u held;
	instr_u cur;

	// alu op from funct3 plus the funct7[5] alternate bit
	function automatic alu_op_e pick_op(input logic [2:0] f3, input logic alt, input logic is_r);
		alu_op_e op;
		case (f3)
			3'b000: op = (is_r && alt) ? alu_sub : alu_add;
			3'b001: op = alu_sll;
			3'b010: op = alu_slt;
			3'b011: op = alu_sltu;
			3'b100: op = alu_xor;
			3'b101: op = alt ? alu_sra : alu_srl;
			3'b110: op = alu_or;
			default: op = alu_and;
		endcase
		return op;
	endfunction

	// word kept for the rest of the instruction
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			held <= '0;
		else if (latch)
			held <= word;
	end

	// decode the fresh word while latching, else the held one
	assign cur = latch ? word : held;

	always_comb
	begin
		dec = '0;
		dec.rs1 = cur.r_fmt.rs1;
		dec.rs2 = cur.r_fmt.rs2;
		dec.rd = cur.r_fmt.rd;
		dec.funct3 = cur.r_fmt.funct3;
		dec.op = alu_add;
		dec.cls = cls_halt;
		case (cur.r_fmt.opcode)
			op_r:
			begin
				dec.cls = cls_alu;
				dec.op = pick_op(cur.r_fmt.funct3, cur.r_fmt.funct7[5], 1'b1);
			end
			op_i:
			begin
				dec.cls = cls_alu;
				dec.use_imm = 1'b1;
				// shift amount sits in imm[4:0], sra flag in imm[10]
				dec.imm = {{20{cur.i_fmt.imm[11]}}, cur.i_fmt.imm};
				dec.op = pick_op(cur.r_fmt.funct3, cur.r_fmt.funct7[5], 1'b0);
			end
			op_load:
			begin
				dec.cls = cls_load;
				dec.use_imm = 1'b1;
				dec.imm = {{20{cur.i_fmt.imm[11]}}, cur.i_fmt.imm};
			end
			op_store:
			begin
				dec.cls = cls_store;
				dec.use_imm = 1'b1;
				dec.imm = {{20{cur.s_fmt.imm_hi[6]}}, cur.s_fmt.imm_hi, cur.s_fmt.imm_lo};
			end
			op_branch:
			begin
				dec.cls = cls_branch;
				dec.imm = {{19{cur.b_fmt.imm12}}, cur.b_fmt.imm12, cur.b_fmt.imm11,
					cur.b_fmt.imm10_5, cur.b_fmt.imm4_1, 1'b0};
			end
			op_jal:
			begin
				dec.cls = cls_jal;
				dec.imm = {{11{cur.j_fmt.imm20}}, cur.j_fmt.imm20, cur.j_fmt.imm19_12,
					cur.j_fmt.imm11, cur.j_fmt.imm10_1, 1'b0};
			end
			// zero word and anything unknown stop the core
			default: dec.cls = cls_halt;
		endcase
	end

endmodule

/* hw/alu.sv */
module alu import rv_pkg::*; (
	input  decoded_t dec,
	input  logic [XLEN-1:0] rs1_val,
	input  logic [XLEN-1:0] rs2_val,
	output logic [XLEN-1:0] result,
	output logic eq,
	output logic lt,
	output logic ltu
);

	logic [XLEN-1:0] op_b;
	logic [4:0] shamt;

	// second operand, register or immediate
	assign op_b = dec.use_imm ? dec.imm : rs2_val;
	assign shamt = op_b[4:0];

	// load and store decode to add, giving the word address
	always_comb
	begin
		case (dec.op)
			alu_add:  result = rs1_val + op_b;
			alu_sub:  result = rs1_val - op_b;
			alu_and:  result = rs1_val & op_b;
			alu_or:   result = rs1_val | op_b;
			alu_xor:  result = rs1_val ^ op_b;
			alu_slt:  result = {31'd0, $signed(rs1_val) < $signed(op_b)};
			alu_sltu: result = {31'd0, rs1_val < op_b};
			alu_sll:  result = rs1_val << shamt;
			alu_srl:  result = rs1_val >> shamt;
			alu_sra:  result = $unsigned($signed(rs1_val) >>> shamt);
			default:  result = rs1_val + op_b;
		endcase
	end

	// branch flags always compare the two registers
	assign eq = (rs1_val == rs2_val);
	assign lt = ($signed(rs1_val) < $signed(rs2_val));
	assign ltu = (rs1_val < rs2_val);

endmodule

/* hw/pc_unit.sv */
module pc_unit import rv_pkg::*; #(
	parameter int ADDR_W = 8
) (
	input  logic clk,
	input  logic rst,
	input  logic pc_en,
	input  decoded_t dec,
	input  logic eq,
	input  logic lt,
	input  logic ltu,
	output logic [ADDR_W-1:0] pc,
	output logic [XLEN-1:0] link
);

	logic [ADDR_W-1:0] offset;
	logic take;

	// byte offset to word offset, wraps with pc width
	assign offset = dec.imm[ADDR_W+1:2];

	always_comb
	begin
		take = 1'b0;
		if (dec.cls == cls_jal)
		begin
			take = 1'b1;
		end
		else if (dec.cls == cls_branch)
		begin
			case (dec.funct3)
				f3_beq:  take = eq;
				f3_bne:  take = !eq;
				f3_blt:  take = lt;
				f3_bge:  take = !lt;
				f3_bltu: take = ltu;
				f3_bgeu: take = !ltu;
				default: take = 1'b0;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			pc <= '0;
		else if (pc_en)
			pc <= take ? (pc + offset) : (pc + ADDR_W'(1));
	end

	// return word index for jal
	assign link = {{(XLEN-ADDR_W){1'b0}}, pc} + XLEN'(1);

endmodule

/* hw/cpu_fsm.sv */
module cpu_fsm import rv_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  logic start,
	input  decoded_t dec,
	input  logic [XLEN-1:0] alu_result,
	input  logic [XLEN-1:0] rs2_val,
	input  logic [XLEN-1:0] link,
	input  logic [XLEN-1:0] dmem_rdata,
	output logic imem_rd_en,
	output logic latch,
	output logic rf_we,
	output logic [XLEN-1:0] rf_wdata,
	output logic pc_en,
	output dmem_req_t dmem_req,
	output logic done
);

	typedef enum logic [2:0] {
		st_idle, st_fetch, st_decode, st_execute, st_mem_wait, st_writeback, st_halt
	} state_e;

	state_e state;
	state_e next_state;
	logic [XLEN-1:0] load_data;

	// ----------------------------------------
	// state register and next state
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst)
	begin
		if (!rst)
			state <= st_idle;
		else
			state <= next_state;
	end

	always_comb
	begin
		next_state = state;
		case (state)
			st_idle:      if (start) next_state = st_fetch;
			st_fetch:     next_state = st_decode;
			// zero word or bad opcode ends the run
			st_decode:    next_state = (dec.cls == cls_halt) ? st_halt : st_execute;
			st_execute:   next_state = (dec.cls == cls_load) ? st_mem_wait : st_writeback;
			st_mem_wait:  next_state = st_writeback;
			st_writeback: next_state = st_fetch;
			st_halt:      next_state = st_halt;
			default:      next_state = st_idle;
		endcase
	end

	// load data arrives one cycle after re
	always_ff @(posedge clk)
	begin
		if (state == st_mem_wait)
			load_data <= dmem_rdata;
	end

	// ----------------------------------------
	// control levels
	// ----------------------------------------
	assign imem_rd_en = (state == st_fetch);
	assign latch = (state == st_decode);
	assign pc_en = (state == st_writeback);
	assign done = (state == st_halt);

	// only these classes touch rd
	assign rf_we = (state == st_writeback) &&
		(dec.cls == cls_alu || dec.cls == cls_load || dec.cls == cls_jal);

	always_comb
	begin
		case (dec.cls)
			cls_jal:  rf_wdata = link;
			cls_load: rf_wdata = load_data;
			default:  rf_wdata = alu_result;
		endcase
	end

	// data bus strobes in execute
	assign dmem_req.re = (state == st_execute) && (dec.cls == cls_load);
	assign dmem_req.we = (state == st_execute) && (dec.cls == cls_store);
	assign dmem_req.addr = alu_result;
	assign dmem_req.wdata = rs2_val;

endmodule

/* hw/cpu_top.sv */
module cpu_top import rv_pkg::*; #(
	parameter int ADDR_W = 8
) (
	input  logic clk,
	input  logic rst,
	input  logic start,
	input  imem_load_t imem_load,
	input  logic [XLEN-1:0] dmem_rdata,
	output dmem_req_t dmem_req,
	output logic done
);

	// ----------------------------------------
	// internal nets
	// ----------------------------------------
	instr_u imem_word;
	decoded_t dec;
	logic imem_rd_en;
	logic latch;
	logic rf_we;
	logic pc_en;
	logic eq;
	logic lt;
	logic ltu;
	logic [ADDR_W-1:0] pc;
	logic [XLEN-1:0] rs1_val;
	logic [XLEN-1:0] rs2_val;
	logic [XLEN-1:0] alu_result;
	logic [XLEN-1:0] rf_wdata;
	logic [XLEN-1:0] link;

	instr_mem #(.ADDR_W(ADDR_W)) u_imem (
		.clk(clk), .rd_addr(pc), .rd_en(imem_rd_en), .load(imem_load), .rd_data(imem_word)
	);

	instr_decode u_decode (
		.clk(clk), .rst(rst), .latch(latch), .word(imem_word), .dec(dec)
	);

	// register file, indices straight from decode
	reg_file u_rf (
		.clk(clk), .rst(rst), .rs1(dec.rs1), .rs2(dec.rs2), .rd(dec.rd),
		.we(rf_we), .wdata(rf_wdata), .rs1_val(rs1_val), .rs2_val(rs2_val)
	);

	alu u_alu (
		.dec(dec), .rs1_val(rs1_val), .rs2_val(rs2_val),
		.result(alu_result), .eq(eq), .lt(lt), .ltu(ltu)
	);

	pc_unit #(.ADDR_W(ADDR_W)) u_pc (
		.clk(clk), .rst(rst), .pc_en(pc_en), .dec(dec),
		.eq(eq), .lt(lt), .ltu(ltu), .pc(pc), .link(link)
	);

	cpu_fsm u_fsm (
		.clk(clk), .rst(rst), .start(start), .dec(dec), .alu_result(alu_result),
		.rs2_val(rs2_val), .link(link), .dmem_rdata(dmem_rdata),
		.imem_rd_en(imem_rd_en), .latch(latch), .rf_we(rf_we), .rf_wdata(rf_wdata),
		.pc_en(pc_en), .dmem_req(dmem_req), .done(done)
	);

endmodule

/* tests/cpu_asserts.sv */
module cpu_asserts (
	input logic clk,
	input logic rst,
	input logic done,
	input logic re,
	input logic we,
	input logic rf_we,
	input logic [2:0] state
);

	// writeback is the sixth state
	localparam logic [2:0] wb_state = 3'd5;

	// done stays up until reset
	done_sticky: assert property (@(posedge clk) disable iff (!rst) done |=> done)
		else $error("done fell without a reset");

	bus_one_strobe: assert property (@(posedge clk) disable iff (!rst) !(re && we))
		else $error("read and write strobes high together");

	rf_we_in_wb: assert property (@(posedge clk) disable iff (!rst) rf_we |-> state == wb_state)
		else $error("register write outside writeback");

endmodule

bind cpu_fsm cpu_asserts u_asserts (
	.clk(clk), .rst(rst), .done(done), .re(dmem_req.re), .we(dmem_req.we),
	.rf_we(rf_we), .state(state)
);

/* tests/cpu_tb_table.svh */
`ifndef CPU_TB_TABLE_SVH
`define CPU_TB_TABLE_SVH

// each row is a program, a data image for words 0..7 and the expected store trace
task automatic build_table();
	// ----------------------------------------
	// row 0, register alu ops
	// ----------------------------------------
	put(0, i_instr(opc_imm, 1, 0, 3'b000, -5));
	put(0, i_instr(opc_imm, 2, 0, 3'b000, 3));
	put(0, r_instr(3'b000, 7'h00, 3, 1, 2));
	put(0, sw_instr(3, 0, 16));
	put(0, r_instr(3'b000, 7'h20, 4, 2, 1));
	put(0, sw_instr(4, 0, 17));
	put(0, r_instr(3'b010, 7'h00, 5, 1, 2));
	put(0, sw_instr(5, 0, 18));
	put(0, r_instr(3'b011, 7'h00, 6, 1, 2));
	put(0, sw_instr(6, 0, 19));
	put(0, r_instr(3'b100, 7'h00, 7, 1, 2));
	put(0, r_instr(3'b101, 7'h20, 8, 1, 2));
	put(0, sw_instr(7, 0, 20));
	put(0, sw_instr(8, 0, 21));
	put(0, 32'h0);
	expect_store(0, 16, 32'hffff_fffe);
	expect_store(0, 17, 32'h0000_0008);
	expect_store(0, 18, 32'h0000_0001);
	expect_store(0, 19, 32'h0000_0000);
	expect_store(0, 20, 32'hffff_fff8);
	expect_store(0, 21, 32'hffff_ffff);
	// row 1, immediate forms and shifts
	put(1, i_instr(opc_imm, 1, 0, 3'b000, -16));
	put(1, i_instr(opc_imm, 2, 1, 3'b101, 1024 + 2));
	put(1, i_instr(opc_imm, 3, 1, 3'b101, 28));
	put(1, i_instr(opc_imm, 4, 1, 3'b001, 4));
	put(1, sw_instr(2, 0, 16));
	put(1, sw_instr(3, 0, 17));
	put(1, sw_instr(4, 0, 18));
	put(1, i_instr(opc_imm, 5, 0, 3'b000, 90));
	put(1, i_instr(opc_imm, 6, 5, 3'b100, 255));
	put(1, i_instr(opc_imm, 7, 1, 3'b111, 60));
	put(1, i_instr(opc_imm, 8, 5, 3'b110, 256));
	put(1, sw_instr(6, 0, 19));
	put(1, sw_instr(7, 0, 20));
	put(1, sw_instr(8, 0, 21));
	put(1, 32'h0);
	expect_store(1, 16, 32'hffff_fffc);
	expect_store(1, 17, 32'h0000_000f);
	expect_store(1, 18, 32'hffff_ff00);
	expect_store(1, 19, 32'h0000_00a5);
	expect_store(1, 20, 32'h0000_0030);
	expect_store(1, 21, 32'h0000_015a);
	// row 2, x0, unwritten reg, lw and jal
	put(2, i_instr(opc_imm, 0, 0, 3'b000, 7));
	put(2, sw_instr(0, 0, 16));
	put(2, sw_instr(9, 0, 17));
	put(2, i_instr(opc_imm, 2, 0, 3'b000, 1));
	put(2, i_instr(opc_load, 1, 2, 3'b010, 3));
	put(2, i_instr(opc_imm, 1, 1, 3'b000, 100));
	put(2, sw_instr(1, 0, 18));
	// word 7 jumps to word 10, link is 8
	put(2, j_instr(3, 12));
	put(2, i_instr(opc_imm, 4, 0, 3'b000, 1));
	put(2, sw_instr(4, 0, 19));
	put(2, sw_instr(3, 0, 20));
	put(2, 32'h0);
	img[2][4] = 32'h1234_5678;
	expect_store(2, 16, 32'h0000_0000);
	expect_store(2, 17, 32'h0000_0000);
	expect_store(2, 18, 32'h1234_56dc);
	expect_store(2, 20, 32'h0000_0008);
	// rows 3 and 4, all six branches on -1 and 1, both orders
	put(3, i_instr(opc_imm, 1, 0, 3'b000, -1));
	put(3, i_instr(opc_imm, 2, 0, 3'b000, 1));
	put(4, i_instr(opc_imm, 1, 0, 3'b000, -1));
	put(4, i_instr(opc_imm, 2, 0, 3'b000, 1));
	foreach (br_f3[k])
	begin
		// taken skips the marker store
		put(3, b_instr(br_f3[k], 1, 2, 8));
		put(3, sw_instr(2, 0, 16 + k));
		put(4, b_instr(br_f3[k], 2, 1, 8));
		put(4, sw_instr(2, 0, 16 + k));
	end
	put(3, 32'h0);
	put(4, 32'h0);
	expect_store(3, 16, 32'h1);
	expect_store(3, 19, 32'h1);
	expect_store(3, 20, 32'h1);
	expect_store(4, 16, 32'h1);
	expect_store(4, 18, 32'h1);
	expect_store(4, 21, 32'h1);
endtask

`endif

/* tests/cpu_tb.sv */
module cpu_tb import rv_pkg::*; ();

	localparam int n_rows = 5;
	localparam logic [6:0] opc_imm = 7'b0010011;
	localparam logic [6:0] opc_load = 7'b0000011;
	localparam logic [2:0] br_f3 [0:5] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};

	logic clk;
	logic rst;
	logic start;
	imem_load_t imem_load;
	logic [31:0] dmem_rdata;
	dmem_req_t dmem_req;
	logic done;

	// table storage
	logic [31:0] prog [0:n_rows-1][0:15];
	int plen [0:n_rows-1];
	logic [31:0] img [0:n_rows-1][0:7];
	logic [31:0] exp_addr [0:n_rows-1][0:7];
	logic [31:0] exp_data [0:n_rows-1][0:7];
	int exp_cnt [0:n_rows-1];
	int bound [0:n_rows-1];

	// data memory model and store trace
	logic [31:0] dmem [0:255];
	logic rd_pending;
	logic [7:0] rd_addr_q;
	logic [31:0] st_addr [0:15];
	logic [31:0] st_data [0:15];
	int st_cnt;
	int cycles;
	int limit;

	cpu_top #(.ADDR_W(8)) uut (
		.clk(clk), .rst(rst), .start(start), .imem_load(imem_load),
		.dmem_rdata(dmem_rdata), .dmem_req(dmem_req), .done(done)
	);

	// standard rv32i encodings
	function automatic logic [31:0] r_instr(input logic [2:0] f3, input logic [6:0] f7,
		input int rd, input int rs1, input int rs2);
		return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'b0110011};
	endfunction

	function automatic logic [31:0] i_instr(input logic [6:0] opc, input int rd,
		input int rs1, input logic [2:0] f3, input int imm);
		return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
	endfunction

	function automatic logic [31:0] sw_instr(input int rs2, input int rs1, input int imm);
		return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
	endfunction

	// offsets in bytes
	function automatic logic [31:0] b_instr(input logic [2:0] f3, input int rs1,
		input int rs2, input int off);
		return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] j_instr(input int rd, input int off);
		return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
	endfunction

	task automatic put(input int row, input logic [31:0] word);
		prog[row][plen[row]] = word;
		plen[row] = plen[row] + 1;
	endtask

	task automatic expect_store(input int row, input logic [31:0] a, input logic [31:0] d);
		exp_addr[row][exp_cnt[row]] = a;
		exp_data[row][exp_cnt[row]] = d;
		exp_cnt[row] = exp_cnt[row] + 1;
	endtask

	`include "cpu_tb_table.svh"

	task automatic check_eq(input logic [31:0] got, input logic [31:0] want, input string msg);
		if (got !== want)
		begin
			$display("ERROR: time %0t %s got %h expected %h", $time, msg, got, want);
			$display("RESULT: FAIL");
			$fatal(1, "mismatch");
		end
	endtask

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ----------------------------------------
	// watchdog
	// ----------------------------------------
	always @(posedge clk)
	begin
		cycles = cycles + 1;
		if (limit > 0 && cycles > limit)
		begin
			$display("timeout, the core did not finish within %0d cycles", limit);
			$display("RESULT: FAIL");
			$fatal(1, "timeout");
		end
	end

	// bus model, read data one cycle after re
	always @(posedge clk)
	begin
		#1;
		if (rd_pending)
			dmem_rdata = dmem[rd_addr_q];
		rd_pending = 1'b0;
		if (dmem_req.re)
		begin
			check_eq(dmem_req.addr & 32'hffff_ff00, 32'h0, "load address range");
			rd_pending = 1'b1;
			rd_addr_q = dmem_req.addr[7:0];
		end
		if (dmem_req.we)
		begin
			check_eq(dmem_req.addr & 32'hffff_ff00, 32'h0, "store address range");
			if (st_cnt > 15)
			begin
				$display("too many stores recorded in one program");
				$display("RESULT: FAIL");
				$fatal(1, "store overflow");
			end
			st_addr[st_cnt] = dmem_req.addr;
			st_data[st_cnt] = dmem_req.wdata;
			st_cnt = st_cnt + 1;
			dmem[dmem_req.addr[7:0]] = dmem_req.wdata;
		end
	end

	initial
	begin
		rst = 1'b0;
		start = 1'b0;
		imem_load = '0;
		dmem_rdata = '0;
		rd_pending = 1'b0;
		rd_addr_q = '0;
		st_cnt = 0;
		cycles = 0;
		limit = 0;
		for (int r = 0; r < n_rows; r++)
		begin
			plen[r] = 0;
			exp_cnt[r] = 0;
			bound[r] = 20;
			for (int k = 0; k < 16; k++)
				prog[r][k] = '0;
			for (int k = 0; k < 8; k++)
				img[r][k] = 32'h0bad_0000 | k;
		end
		build_table();
		for (int r = 0; r < n_rows; r++)
			limit = limit + plen[r] + 5 * bound[r];
		limit = limit + 20;

		for (int r = 0; r < n_rows; r++)
		begin
			// reset and memory image
			@(posedge clk);
			#1;
			rst = 1'b0;
			st_cnt = 0;
			for (int a = 0; a < 256; a++)
				dmem[a] = {24'hc0de00, a[7:0]};
			for (int a = 0; a < 8; a++)
				dmem[a] = img[r][a];
			repeat (3) @(posedge clk);
			#1;
			rst = 1'b1;
			// program load, padded with zero words
			for (int k = 0; k < 16; k++)
			begin
				imem_load.we = 1'b1;
				imem_load.addr = k;
				imem_load.data = prog[r][k];
				@(posedge clk);
				#1;
			end
			imem_load = '0;
			start = 1'b1;
			@(posedge clk);
			#1;
			start = 1'b0;
			while (!done)
			begin
				@(posedge clk);
				#1;
			end
			// nothing may follow the halt
			repeat (4) @(posedge clk);
			#1;
			check_eq({31'd0, done}, 32'd1, "done held");
			check_eq(st_cnt, exp_cnt[r], "store count");
			for (int k = 0; k < exp_cnt[r]; k++)
			begin
				check_eq(st_addr[k], exp_addr[r][k], $sformatf("row %0d store %0d addr", r, k));
				check_eq(st_data[k], exp_data[r][k], $sformatf("row %0d store %0d data", r, k));
			end
		end

		$display("RESULT: PASS");
		$finish;
	end

endmodule

/* mini_rv.f */
+incdir+tests
hw/rv_pkg.sv
hw/instr_mem.sv
hw/reg_file.sv
hw/instr_decode.sv
hw/alu.sv
hw/pc_unit.sv
hw/cpu_fsm.sv
hw/cpu_top.sv
tests/cpu_asserts.sv
tests/cpu_tb.sv

/* run.sh */
#!/bin/sh
# build and run the mini_rv testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f mini_rv.f --top-module cpu_tb -o cpu_tb_sim
status=$?
if [ $status -ne 0 ]; then
	echo "build failed"
	exit $status
fi

./obj_dir/cpu_tb_sim
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed"
	exit $status
fi

exit 0
